// File: build.f
+incdir+.
soc_bus_pkg.sv
bus_host_port.sv
bus_mailbox.sv
bus_controller.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: bus_controller.sv
`include "soc_consts.svh"

module bus_controller (
    input  logic                                          clk50MHz,
    input  logic                                          rst,
    input  logic [`NUM_REQ-1:0]                           req,
    input  logic [`NUM_REQ*`DATA_W-1:0]                   bus_in_flat,
    input  logic [`NUM_REQ*$bits(soc_bus_pkg::bus_ctrl_t)-1:0] ctrl_in_flat,
    output logic [`NUM_REQ-1:0]                           ack,
    output logic [`DATA_W-1:0]                            bus_data,
    output soc_bus_pkg::bus_ctrl_t                        bus_ctrl
);
    import soc_bus_pkg::*;

    localparam int CTRL_W = $bits(bus_ctrl_t);
    localparam int PTR_W  = $clog2(`NUM_REQ);

    localparam bus_ctrl_t IDLE_CTRL = '{
        op:   OP_IDLE,
        dest: '0,
        src:  '0,
        addr: '0
    };

    logic [PTR_W-1:0]    last_grant;
    logic [`NUM_REQ-1:0] eligible;
    logic [`NUM_REQ-1:0] grant;
    logic [PTR_W-1:0]    grant_idx;
    logic                grant_valid;
    logic [`DATA_W-1:0]  sel_data;
    bus_ctrl_t           sel_ctrl;

    // requester acked last cycle still holds req and sits out
    assign eligible = req & ~ack;

    always_comb begin
        int idx;
        grant       = '0;
        grant_idx   = last_grant;
        grant_valid = 1'b0;
        for (int i = 1; i <= `NUM_REQ; i++) begin
            idx = (int'(last_grant) + i) % `NUM_REQ;   // start after last winner
            if (!grant_valid && eligible[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = PTR_W'(idx);
            end
        end
        if (grant_valid) begin
            grant[grant_idx] = 1'b1;
        end
    end

    assign sel_data = bus_in_flat[grant_idx*`DATA_W +: `DATA_W];
    assign sel_ctrl = bus_ctrl_t'(ctrl_in_flat[grant_idx*CTRL_W +: CTRL_W]);

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            ack        <= '0;
            last_grant <= PTR_W'(`NUM_REQ - 1);    // slot 0 wins first
            bus_ctrl   <= IDLE_CTRL;
        end else begin
            ack      <= grant;
            bus_ctrl <= grant_valid ? sel_ctrl : IDLE_CTRL;   // one cycle only
            if (grant_valid) begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (grant_valid) begin
            bus_data <= sel_data;
        end
    end

    // agents hold req through the ack cycle
    a_ack_to_req: assert property (
        @(posedge clk50MHz) disable iff (rst)
        (ack & ~req) == '0
    );

endmodule

// File: bus_host_port.sv
`include "soc_consts.svh"

module bus_host_port (
    input  logic                    clk50MHz,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  logic                    cmd_write,
    input  soc_bus_pkg::agent_id_t  cmd_dev,
    input  logic [`WORD_ADDR_W-1:0] cmd_addr,
    input  logic [`DATA_W-1:0]      cmd_wdata,
    input  logic                    ack,
    input  logic [`DATA_W-1:0]      bus_data,
    input  soc_bus_pkg::bus_ctrl_t  bus_ctrl,
    output logic                    busy,
    output logic                    rsp_valid,
    output logic                    rsp_err,
    output logic [`DATA_W-1:0]      rsp_data,
    output logic                    req,
    output logic [`DATA_W-1:0]      bus_in,
    output soc_bus_pkg::bus_ctrl_t  ctrl_in
);
    import soc_bus_pkg::*;

    localparam int TO_W = $clog2(`RSP_TIMEOUT + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_DONE
    } state_t;

    state_t          state;
    logic [TO_W-1:0] to_cnt;
    logic            accept;
    logic            reply_hit;
    logic            timed_out;

    assign accept    = cmd_valid && (state == S_IDLE || state == S_DONE);
    assign reply_hit = (bus_ctrl.op == OP_REPLY) && (bus_ctrl.dest == `ID_W'(`HOST_ID));
    assign timed_out = (to_cnt == TO_W'(`RSP_TIMEOUT - 1));

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state     <= S_IDLE;
            req       <= 1'b0;
            busy      <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
            to_cnt    <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    rsp_valid <= 1'b0;
                    rsp_err   <= 1'b0;
                    state     <= accept ? S_REQ : S_IDLE;
                end
                S_REQ: begin
                    if (ack) begin
                        req <= 1'b0;                  // drop on the edge after ack
                        if (ctrl_in.op == OP_WRITE) begin
                            busy  <= 1'b0;
                            state <= S_DONE;
                        end else begin
                            to_cnt <= '0;
                            state  <= S_WAIT;
                        end
                    end else begin
                        req  <= 1'b1;
                        busy <= 1'b1;
                    end
                end
                S_WAIT: begin
                    if (reply_hit || timed_out) begin
                        rsp_valid <= 1'b1;
                        rsp_err   <= !reply_hit;
                        busy      <= 1'b0;
                        state     <= S_DONE;
                    end else begin
                        to_cnt <= to_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // command words held stable until the next accept
    always_ff @(posedge clk50MHz) begin
        if (accept) begin
            bus_in       <= cmd_wdata;
            ctrl_in.op   <= cmd_write ? OP_WRITE : OP_READ;
            ctrl_in.dest <= cmd_dev;
            ctrl_in.src  <= `ID_W'(`HOST_ID);
            ctrl_in.addr <= cmd_addr;
        end
        if (state == S_WAIT && reply_hit) begin
            rsp_data <= bus_data;
        end else if (state == S_WAIT && timed_out) begin
            rsp_data <= '0;                           // no reply came back
        end
    end

endmodule

// File: bus_mailbox.sv
`include "soc_consts.svh"

module bus_mailbox (
    input  logic                   clk50MHz,
    input  logic                   rst,
    input  soc_bus_pkg::agent_id_t dev_id,
    input  logic [`DATA_W-1:0]     status,
    input  logic [`DATA_W-1:0]     bus_data,
    input  soc_bus_pkg::bus_ctrl_t bus_ctrl,
    input  logic                   ack,
    output logic [`DATA_W-1:0]     word0,
    output logic                   req,
    output logic [`DATA_W-1:0]     bus_in,
    output soc_bus_pkg::bus_ctrl_t ctrl_in
);
    import soc_bus_pkg::*;

    localparam int NUM_WORDS = 3;                    // word 3 is the status input

    logic [`DATA_W-1:0] word_r [NUM_WORDS];
    logic [`DATA_W-1:0] rd_word;
    logic               addr_hit;
    logic               write_hit;
    logic               read_hit;

    assign addr_hit  = (bus_ctrl.dest == dev_id);
    assign write_hit = addr_hit && (bus_ctrl.op == OP_WRITE);
    assign read_hit  = addr_hit && (bus_ctrl.op == OP_READ);

    assign word0 = word_r[0];

    always_comb begin
        case (bus_ctrl.addr)
            2'd0:    rd_word = word_r[0];
            2'd1:    rd_word = word_r[1];
            2'd2:    rd_word = word_r[2];
            default: rd_word = status;               // live value, read only
        endcase
    end

    // writable words, a write to word 3 falls through
    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                word_r[i] <= '0;
            end
        end else if (write_hit) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                if (bus_ctrl.addr == `WORD_ADDR_W'(i)) begin
                    word_r[i] <= bus_data;
                end
            end
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            req <= 1'b0;
        end else if (read_hit) begin
            req <= 1'b1;                             // reply on the next edge
        end else if (ack) begin
            req <= 1'b0;
        end
    end

    // reply words, captured with the read and held until ack
    always_ff @(posedge clk50MHz) begin
        if (read_hit) begin
            bus_in       <= rd_word;
            ctrl_in.op   <= OP_REPLY;
            ctrl_in.dest <= bus_ctrl.src;            // back to the reader
            ctrl_in.src  <= dev_id;
            ctrl_in.addr <= bus_ctrl.addr;
        end
    end

    // host issues one command at a time, so no read can overlap a reply
    a_no_read_while_pending: assert property (
        @(posedge clk50MHz) disable iff (rst)
        read_hit |-> !req
    );

    // reply stays put while the controller has not granted it
    a_reply_stable: assert property (
        @(posedge clk50MHz) disable iff (rst)
        (req && !ack) |=> ($stable(bus_in) && $stable(ctrl_in))
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_soc_bus \
    -f build.f \
    -o tb_soc_bus_sim

./obj_dir/tb_soc_bus_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed, see sim.log"
    exit 1
fi

// File: soc_bus_pkg.sv
`include "soc_consts.svh"

package soc_bus_pkg;

    // operation carried by one broadcast cycle
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,                  // nothing on the bus
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_REPLY = 2'd3                   // read data going back to src
    } bus_op_t;

    typedef logic [`ID_W-1:0] agent_id_t;

    // control word that travels next to each data word
    typedef struct packed {
        bus_op_t                 op;
        agent_id_t               dest;
        agent_id_t               src;
        logic [`WORD_ADDR_W-1:0] addr;   // word inside the mailbox
    } bus_ctrl_t;

endpackage

// File: soc_bus_top.sv
`include "soc_consts.svh"

module soc_bus_top (
    input  logic                        clk50MHz,
    input  logic                        rst,
    input  logic                        cmd_valid,
    input  logic                        cmd_write,
    input  soc_bus_pkg::agent_id_t      cmd_dev,
    input  logic [`WORD_ADDR_W-1:0]     cmd_addr,
    input  logic [`DATA_W-1:0]          cmd_wdata,
    input  logic [`NUM_DEV*`DATA_W-1:0] status_flat,
    output logic                        busy,
    output logic                        rsp_valid,
    output logic                        rsp_err,
    output logic [`DATA_W-1:0]          rsp_data,
    output logic [`NUM_DEV*`DATA_W-1:0] mbox_word0_flat
);
    import soc_bus_pkg::*;

    localparam int CTRL_W = $bits(bus_ctrl_t);

    logic [`NUM_REQ-1:0]         req;
    logic [`NUM_REQ-1:0]         ack;
    logic [`NUM_REQ*`DATA_W-1:0] bus_in_flat;
    logic [`NUM_REQ*CTRL_W-1:0]  ctrl_in_flat;
    logic [`DATA_W-1:0]          bus_data;
    bus_ctrl_t                   bus_ctrl;

    bus_host_port u_host_port (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_dev   (cmd_dev),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .ack       (ack[`HOST_ID]),
        .bus_data  (bus_data),
        .bus_ctrl  (bus_ctrl),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_err   (rsp_err),
        .rsp_data  (rsp_data),
        .req       (req[`HOST_ID]),
        .bus_in    (bus_in_flat[`HOST_ID*`DATA_W +: `DATA_W]),
        .ctrl_in   (ctrl_in_flat[`HOST_ID*CTRL_W +: CTRL_W])
    );

    // slot i of the controller is mailbox i
    for (genvar i = 0; i < `NUM_DEV; i++) begin : g_mbox
        bus_mailbox u_mailbox (
            .clk50MHz (clk50MHz),
            .rst      (rst),
            .dev_id   (`ID_W'(i)),
            .status   (status_flat[i*`DATA_W +: `DATA_W]),
            .bus_data (bus_data),
            .bus_ctrl (bus_ctrl),
            .ack      (ack[i]),
            .word0    (mbox_word0_flat[i*`DATA_W +: `DATA_W]),
            .req      (req[i]),
            .bus_in   (bus_in_flat[i*`DATA_W +: `DATA_W]),
            .ctrl_in  (ctrl_in_flat[i*CTRL_W +: CTRL_W])
        );
    end

    bus_controller u_bus_controller (
        .clk50MHz     (clk50MHz),
        .rst          (rst),
        .req          (req),
        .bus_in_flat  (bus_in_flat),
        .ctrl_in_flat (ctrl_in_flat),
        .ack          (ack),
        .bus_data     (bus_data),
        .bus_ctrl     (bus_ctrl)
    );

endmodule

// File: soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// bus word and agent sizes
`define DATA_W 32
`define ID_W 3
`define WORD_ADDR_W 2

// agents on the bus
`define NUM_DEV 4
`define HOST_ID 4                    // mailboxes take 0 to 3, 5 to 7 unused
`define NUM_REQ (`NUM_DEV + 1)       // mailboxes plus host

// cycles the host waits for a read reply after ack
`define RSP_TIMEOUT 32

`endif

// File: tb_soc_bus.sv
`include "soc_consts.svh"

module tb_soc_bus;
    timeunit 1ns;
    timeprecision 100ps;

    import soc_bus_pkg::*;

    localparam int BUSY_LIMIT = `RSP_TIMEOUT + 8 * `NUM_REQ;

    logic                        clk50MHz = 1'b0;
    logic                        rst;
    logic                        cmd_valid;
    logic                        cmd_write;
    agent_id_t                   cmd_dev;
    logic [`WORD_ADDR_W-1:0]     cmd_addr;
    logic [`DATA_W-1:0]          cmd_wdata;
    logic [`NUM_DEV*`DATA_W-1:0] status_flat;
    logic                        busy;
    logic                        rsp_valid;
    logic                        rsp_err;
    logic [`DATA_W-1:0]          rsp_data;
    logic [`NUM_DEV*`DATA_W-1:0] mbox_word0_flat;

    logic [`DATA_W-1:0] model [`NUM_DEV][3];   // words 0 to 2 of each mailbox
    int                 errors;
    int                 checks;

    soc_bus_top u_soc_bus_top (
        .clk50MHz        (clk50MHz),
        .rst             (rst),
        .cmd_valid       (cmd_valid),
        .cmd_write       (cmd_write),
        .cmd_dev         (cmd_dev),
        .cmd_addr        (cmd_addr),
        .cmd_wdata       (cmd_wdata),
        .status_flat     (status_flat),
        .busy            (busy),
        .rsp_valid       (rsp_valid),
        .rsp_err         (rsp_err),
        .rsp_data        (rsp_data),
        .mbox_word0_flat (mbox_word0_flat)
    );

    always #10 clk50MHz = ~clk50MHz;

    task automatic report_timeout(input string what);
        errors++;
        $display("ERROR: timed out waiting for %s", what);
    endtask

    task automatic compare_value(input string name, input logic [`DATA_W-1:0] exp,
                                 input logic [`DATA_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    // status word comes from the input, the rest from the model
    function automatic logic [`DATA_W-1:0] expected_word(input logic [1:0] dev,
                                                         input logic [1:0] addr);
        if (addr == 2'd3) begin
            return status_flat[dev*`DATA_W +: `DATA_W];
        end
        return model[dev][addr];
    endfunction

    task automatic wait_busy_rise();
        int n;
        n = 0;
        while (!busy && n < 8) begin
            @(posedge clk50MHz);
            #1;
            n++;
        end
        if (!busy) begin
            report_timeout("busy to rise");
        end
    endtask

    task automatic wait_busy_fall(output int cycles);
        int n;
        n = 0;
        while (busy && n < BUSY_LIMIT) begin
            assert (!rsp_valid) else begin
                errors++;
                $display("ERROR: rsp_valid went high while busy was still high");
            end
            @(posedge clk50MHz);
            #1;
            n++;
        end
        if (busy) begin
            report_timeout("busy to fall");
        end
        cycles = n;
    endtask

    // one command strobe, then the whole busy window
    task automatic send_command(input logic wr, input agent_id_t dev,
                                input logic [1:0] addr, input logic [`DATA_W-1:0] data,
                                output int cycles);
        cmd_write = wr;
        cmd_dev   = dev;
        cmd_addr  = addr;
        cmd_wdata = data;
        cmd_valid = 1'b1;
        @(posedge clk50MHz);
        #1;
        cmd_valid = 1'b0;
        wait_busy_rise();
        wait_busy_fall(cycles);
    endtask

    task automatic write_word(input logic [1:0] dev, input logic [1:0] addr,
                              input logic [`DATA_W-1:0] data);
        int cycles;
        send_command(1'b1, agent_id_t'(dev), addr, data, cycles);
        if (addr != 2'd3) begin
            model[dev][addr] = data;
        end
    endtask

    task automatic read_word(input string name, input logic [1:0] dev, input logic [1:0] addr);
        int cycles;
        send_command(1'b0, agent_id_t'(dev), addr, '0, cycles);
        compare_value({name, " rsp_valid"}, 32'd1, 32'(rsp_valid));
        compare_value({name, " rsp_err"}, 32'd0, 32'(rsp_err));
        compare_value({name, " rsp_data"}, expected_word(dev, addr), rsp_data);
    endtask

    task automatic reset_values();
        compare_value("reset busy", 32'd0, 32'(busy));
        compare_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
        compare_value("reset rsp_err", 32'd0, 32'(rsp_err));
        for (int d = 0; d < `NUM_DEV; d++) begin
            compare_value("reset word0", '0, mbox_word0_flat[d*`DATA_W +: `DATA_W]);
        end
    endtask

    task automatic write_then_read_all();
        for (int d = 0; d < `NUM_DEV; d++) begin
            for (int a = 0; a < 3; a++) begin
                write_word(2'(d), 2'(a), $urandom);
            end
            compare_value("word0 output", model[d][0], mbox_word0_flat[d*`DATA_W +: `DATA_W]);
            for (int a = 0; a < 3; a++) begin
                read_word("write then read", 2'(d), 2'(a));
            end
        end
    endtask

    task automatic status_word_read_only();
        for (int d = 0; d < `NUM_DEV; d++) begin
            read_word("status read", 2'(d), 2'd3);
            write_word(2'(d), 2'd3, $urandom);
            read_word("status after write", 2'(d), 2'd3);
        end
    endtask

    task automatic unused_id_timeout();
        int cycles;
        send_command(1'b0, agent_id_t'(6), 2'd0, '0, cycles);
        compare_value("unused id rsp_valid", 32'd1, 32'(rsp_valid));
        compare_value("unused id rsp_err", 32'd1, 32'(rsp_err));
        compare_value("unused id rsp_data", '0, rsp_data);
        checks++;
        assert (cycles >= `RSP_TIMEOUT) else begin
            errors++;
            $display("ERROR: busy fell %0d cycles into a read with no reply", cycles);
        end
    endtask

    task automatic ignore_cmd_while_busy();
        int cycles;
        cmd_write = 1'b0;                      // read of mailbox 1, word 2
        cmd_dev   = agent_id_t'(1);
        cmd_addr  = 2'd2;
        cmd_wdata = '0;
        cmd_valid = 1'b1;
        @(posedge clk50MHz);
        #1;
        cmd_valid = 1'b0;
        wait_busy_rise();
        cmd_write = 1'b1;                      // must be dropped
        cmd_dev   = agent_id_t'(1);
        cmd_addr  = 2'd2;
        cmd_wdata = ~model[1][2];
        cmd_valid = 1'b1;
        @(posedge clk50MHz);
        #1;
        cmd_valid = 1'b0;
        wait_busy_fall(cycles);
        compare_value("busy cmd rsp_data", model[1][2], rsp_data);
        compare_value("busy cmd rsp_err", 32'd0, 32'(rsp_err));
        repeat (4) begin
            @(posedge clk50MHz);
            #1;
            compare_value("busy cmd no restart", 32'd0, 32'(busy));
        end
        read_word("busy cmd read back", 2'd1, 2'd2);
        for (int d = 0; d < `NUM_DEV; d++) begin
            compare_value("busy cmd word0", model[d][0], mbox_word0_flat[d*`DATA_W +: `DATA_W]);
        end
    endtask

    task automatic random_traffic();
        logic [1:0] dev;
        logic [1:0] addr;
        logic       wr;
        for (int d = 0; d < `NUM_DEV; d++) begin
            status_flat[d*`DATA_W +: `DATA_W] = $urandom;   // fresh status values
        end
        repeat (200) begin
            dev  = 2'($urandom % 4);
            addr = 2'($urandom % 4);
            wr   = 1'($urandom % 2);
            if (wr) begin
                write_word(dev, addr, $urandom);
                compare_value("random word0", model[dev][0],
                              mbox_word0_flat[dev*`DATA_W +: `DATA_W]);
            end else begin
                read_word("random read", dev, addr);
            end
        end
    endtask

    initial begin
        void'($urandom(96943));
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_dev   = '0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        for (int d = 0; d < `NUM_DEV; d++) begin
            status_flat[d*`DATA_W +: `DATA_W] = $urandom;
            for (int a = 0; a < 3; a++) begin
                model[d][a] = '0;
            end
        end
        repeat (4) @(posedge clk50MHz);
        #1;
        rst = 1'b0;

        reset_values();
        write_then_read_all();
        status_word_read_only();
        unused_id_timeout();
        ignore_cmd_while_busy();
        random_traffic();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
